/* Makefile */
# Verilator build and run of the byte strobe subsystem testbench

TOP             ?= strb_subsys_tb
LINT_TOP        ?= strb_subsys_top
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS      ?= --lint-only -Wall --timing
SEED_ARGS       ?= +verilator+seed+1
BUILD_DIR       ?= obj_dir
LOG             ?= sim.log
PASS_MSG        ?= All checks passed

.PHONY: all build run check lint clean

all: check

build:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f sources.f --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SEED_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)

check: run
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f sources.f

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rtl/mem_cfg_pkg.sv */
// ############################
// Memory channel configuration
// Widths of the address, data,
// strobe and tag fields shared
// by all q and p channels
// ############################

package mem_cfg_pkg;

	// Data word width in bits
	localparam int unsigned DataWidth = 32;

	// One strobe bit per byte
	localparam int unsigned StrbWidth = DataWidth / 8;

	// Word address, 256 words deep
	localparam int unsigned AddrWidth = 8;

	// User tag echoed in every response
	localparam int unsigned UserWidth = 4;

	// Strobe with every byte enabled
	localparam logic [StrbWidth-1:0] FullStrb = {StrbWidth{1'b1}};

endpackage

/* rtl/nostrb_mem.sv */
// ############################
// Word memory without strobes
// Whole-word reads and writes,
// one response per request one
// cycle after it is accepted
// ############################

`timescale 1ns/1ps

module nostrb_mem (
	input  logic                              clk_i,
	input  logic                              rst_n_i,
	input  logic                              q_valid_i,
	input  logic [mem_cfg_pkg::AddrWidth-1:0] q_addr_i,
	input  logic                              q_write_i,
	input  logic [mem_cfg_pkg::DataWidth-1:0] q_data_i,
	input  logic [mem_cfg_pkg::StrbWidth-1:0] q_strb_i,
	input  logic [mem_cfg_pkg::UserWidth-1:0] q_user_i,
	output logic                              q_ready_o,
	input  logic                              p_ready_i,
	output logic                              p_valid_o,
	output logic [mem_cfg_pkg::DataWidth-1:0] p_data_o,
	output logic [mem_cfg_pkg::UserWidth-1:0] p_user_o
);

	localparam int unsigned Depth = 2 ** mem_cfg_pkg::AddrWidth;

	logic [mem_cfg_pkg::DataWidth-1:0] mem_q [Depth];
	logic p_valid_q;
	logic req_fire;

	// Free when no response waits, or the waiting one leaves now
	assign q_ready_o = !p_valid_q || p_ready_i;
	assign req_fire  = q_valid_i && q_ready_o;

	// Word array, whole words only
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < Depth; i++) begin
				mem_q[i] <= '0;
			end
		end else if (req_fire && q_write_i) begin
			mem_q[q_addr_i] <= q_data_i;
		end
	end

	// Response valid, held while p_ready is low
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			p_valid_q <= 1'b0;
		end else if (req_fire) begin
			p_valid_q <= 1'b1;
		end else if (p_ready_i) begin
			p_valid_q <= 1'b0;
		end
	end

	// Write echoes its data, read returns the stored word
	always_ff @(posedge clk_i) begin
		if (req_fire) begin
			p_data_o <= q_write_i ? q_data_i : mem_q[q_addr_i];
			p_user_o <= q_user_i;
		end
	end

	assign p_valid_o = p_valid_q;

	// Strobe handling upstream must hand over whole-word writes only
	a_write_full_strb : assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(req_fire && q_write_i) |-> (q_strb_i == mem_cfg_pkg::FullStrb))
		else $error("memory accepted a write with partial strobe %h", q_strb_i);

endmodule

/* rtl/req_spill_reg.sv */
// ############################
// Request spill register
// One-entry buffer between the
// core q channel and the strobe
// handler, holds its payload
// under back-pressure
// ############################

`timescale 1ns/1ps

module req_spill_reg (
	input  logic                              clk_i,
	input  logic                              rst_n_i,
	input  logic                              s_q_valid_i,
	input  logic [mem_cfg_pkg::AddrWidth-1:0] s_q_addr_i,
	input  logic                              s_q_write_i,
	input  logic [mem_cfg_pkg::DataWidth-1:0] s_q_data_i,
	input  logic [mem_cfg_pkg::StrbWidth-1:0] s_q_strb_i,
	input  logic [mem_cfg_pkg::UserWidth-1:0] s_q_user_i,
	output logic                              s_q_ready_o,
	output logic                              m_q_valid_o,
	output logic [mem_cfg_pkg::AddrWidth-1:0] m_q_addr_o,
	output logic                              m_q_write_o,
	output logic [mem_cfg_pkg::DataWidth-1:0] m_q_data_o,
	output logic [mem_cfg_pkg::StrbWidth-1:0] m_q_strb_o,
	output logic [mem_cfg_pkg::UserWidth-1:0] m_q_user_o,
	input  logic                              m_q_ready_i
);

	logic full_q;
	logic load;

	// Accept when empty or when the held entry leaves this cycle
	assign s_q_ready_o = !full_q || m_q_ready_i;
	assign load        = s_q_valid_i && s_q_ready_o;

	// Occupancy flag
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			full_q <= 1'b0;
		end else if (s_q_ready_o) begin
			// Refilled by a new request or drained to the handler
			full_q <= s_q_valid_i;
		end
	end

	// Payload only changes on a new accept
	always_ff @(posedge clk_i) begin
		if (load) begin
			m_q_addr_o  <= s_q_addr_i;
			m_q_write_o <= s_q_write_i;
			m_q_data_o  <= s_q_data_i;
			m_q_strb_o  <= s_q_strb_i;
			m_q_user_o  <= s_q_user_i;
		end
	end

	assign m_q_valid_o = full_q;

	// Stalled entry keeps valid and payload, the handler tag match depends on it
	a_stable_payload : assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(m_q_valid_o && !m_q_ready_i) |=> (m_q_valid_o && $stable({m_q_addr_o, m_q_write_o,
		m_q_data_o, m_q_strb_o, m_q_user_o})))
		else $error("spill register payload changed while stalled");

endmodule

/* rtl/rmw_pkg.sv */
// ############################
// Read-modify-write handler
// State encoding and byte size
// of the strobe merge
// ############################

package rmw_pkg;

	// Partial write handling states
	typedef enum logic [1:0] {
		ST_IDLE_READ,
		ST_READ_WAIT,
		ST_WRITE,
		ST_WRITE_WAIT
	} strb_state_e;

	localparam strb_state_e ResetState = ST_IDLE_READ;

	// Bits covered by one strobe bit
	localparam int unsigned ByteWidth = 8;

endpackage

/* rtl/strb_subsys_top.sv */
// ############################
// Byte strobe subsystem top
// Spill register, strobe handler
// and word memory in a chain
// ############################

`timescale 1ns/1ps

module strb_subsys_top (
	input  logic                              clk_i,
	input  logic                              rst_n_i,
	input  logic                              core_q_valid_i,
	input  logic [mem_cfg_pkg::AddrWidth-1:0] core_q_addr_i,
	input  logic                              core_q_write_i,
	input  logic [mem_cfg_pkg::DataWidth-1:0] core_q_data_i,
	input  logic [mem_cfg_pkg::StrbWidth-1:0] core_q_strb_i,
	input  logic [mem_cfg_pkg::UserWidth-1:0] core_q_user_i,
	output logic                              core_q_ready_o,
	input  logic                              core_p_ready_i,
	output logic                              core_p_valid_o,
	output logic [mem_cfg_pkg::DataWidth-1:0] core_p_data_o,
	output logic [mem_cfg_pkg::UserWidth-1:0] core_p_user_o
);

	// Spill register to handler
	logic                              in_q_valid;
	logic [mem_cfg_pkg::AddrWidth-1:0] in_q_addr;
	logic                              in_q_write;
	logic [mem_cfg_pkg::DataWidth-1:0] in_q_data;
	logic [mem_cfg_pkg::StrbWidth-1:0] in_q_strb;
	logic [mem_cfg_pkg::UserWidth-1:0] in_q_user;
	logic                              in_q_ready;

	// Handler to memory and back
	logic                              mem_q_valid;
	logic [mem_cfg_pkg::AddrWidth-1:0] mem_q_addr;
	logic                              mem_q_write;
	logic [mem_cfg_pkg::DataWidth-1:0] mem_q_data;
	logic [mem_cfg_pkg::StrbWidth-1:0] mem_q_strb;
	logic [mem_cfg_pkg::UserWidth-1:0] mem_q_user;
	logic                              mem_q_ready;
	logic                              mem_p_valid;
	logic [mem_cfg_pkg::DataWidth-1:0] mem_p_data;
	logic [mem_cfg_pkg::UserWidth-1:0] mem_p_user;
	logic                              mem_p_ready;

	req_spill_reg i_spill (
		.clk_i, .rst_n_i,
		.s_q_valid_i(core_q_valid_i), .s_q_addr_i(core_q_addr_i), .s_q_write_i(core_q_write_i),
		.s_q_data_i(core_q_data_i), .s_q_strb_i(core_q_strb_i), .s_q_user_i(core_q_user_i),
		.s_q_ready_o(core_q_ready_o),
		.m_q_valid_o(in_q_valid), .m_q_addr_o(in_q_addr), .m_q_write_o(in_q_write),
		.m_q_data_o(in_q_data), .m_q_strb_o(in_q_strb), .m_q_user_o(in_q_user),
		.m_q_ready_i(in_q_ready)
	);

	strbreq_handler i_handler (
		.clk_i, .rst_n_i,
		.in_q_valid_i(in_q_valid), .in_q_addr_i(in_q_addr), .in_q_write_i(in_q_write),
		.in_q_data_i(in_q_data), .in_q_strb_i(in_q_strb), .in_q_user_i(in_q_user),
		.in_q_ready_o(in_q_ready),
		.in_p_ready_i(core_p_ready_i), .in_p_valid_o(core_p_valid_o),
		.in_p_data_o(core_p_data_o), .in_p_user_o(core_p_user_o),
		.mem_q_valid_o(mem_q_valid), .mem_q_addr_o(mem_q_addr), .mem_q_write_o(mem_q_write),
		.mem_q_data_o(mem_q_data), .mem_q_strb_o(mem_q_strb), .mem_q_user_o(mem_q_user),
		.mem_q_ready_i(mem_q_ready),
		.mem_p_valid_i(mem_p_valid), .mem_p_data_i(mem_p_data), .mem_p_user_i(mem_p_user),
		.mem_p_ready_o(mem_p_ready)
	);

	nostrb_mem i_mem (
		.clk_i, .rst_n_i,
		.q_valid_i(mem_q_valid), .q_addr_i(mem_q_addr), .q_write_i(mem_q_write),
		.q_data_i(mem_q_data), .q_strb_i(mem_q_strb), .q_user_i(mem_q_user),
		.q_ready_o(mem_q_ready),
		.p_ready_i(mem_p_ready), .p_valid_o(mem_p_valid),
		.p_data_o(mem_p_data), .p_user_o(mem_p_user)
	);

endmodule

/* rtl/strbreq_handler.sv */
// ############################
// Byte strobe request handler
// Passes reads and full writes
// through, turns a partial write
// into a read, a byte merge and
// a full-word write back
// ############################

`timescale 1ns/1ps

module strbreq_handler (
	input  logic                              clk_i,
	input  logic                              rst_n_i,
	input  logic                              in_q_valid_i,
	input  logic [mem_cfg_pkg::AddrWidth-1:0] in_q_addr_i,
	input  logic                              in_q_write_i,
	input  logic [mem_cfg_pkg::DataWidth-1:0] in_q_data_i,
	input  logic [mem_cfg_pkg::StrbWidth-1:0] in_q_strb_i,
	input  logic [mem_cfg_pkg::UserWidth-1:0] in_q_user_i,
	output logic                              in_q_ready_o,
	input  logic                              in_p_ready_i,
	output logic                              in_p_valid_o,
	output logic [mem_cfg_pkg::DataWidth-1:0] in_p_data_o,
	output logic [mem_cfg_pkg::UserWidth-1:0] in_p_user_o,
	output logic                              mem_q_valid_o,
	output logic [mem_cfg_pkg::AddrWidth-1:0] mem_q_addr_o,
	output logic                              mem_q_write_o,
	output logic [mem_cfg_pkg::DataWidth-1:0] mem_q_data_o,
	output logic [mem_cfg_pkg::StrbWidth-1:0] mem_q_strb_o,
	output logic [mem_cfg_pkg::UserWidth-1:0] mem_q_user_o,
	input  logic                              mem_q_ready_i,
	input  logic                              mem_p_valid_i,
	input  logic [mem_cfg_pkg::DataWidth-1:0] mem_p_data_i,
	input  logic [mem_cfg_pkg::UserWidth-1:0] mem_p_user_i,
	output logic                              mem_p_ready_o
);

	rmw_pkg::strb_state_e state_d, state_q;

	// Old word returned by the inserted read
	logic [mem_cfg_pkg::DataWidth-1:0] rd_data_d, rd_data_q;
	logic [mem_cfg_pkg::DataWidth-1:0] merged_data;
	logic partial_write;
	logic rsp_match;

	assign partial_write = in_q_write_i && (in_q_strb_i != mem_cfg_pkg::FullStrb);
	// Response that belongs to the request under handling
	assign rsp_match     = mem_p_valid_i && (mem_p_user_i == in_q_user_i);

	// Address, tag and response payload always pass straight through
	assign mem_q_addr_o = in_q_addr_i;
	assign mem_q_user_o = in_q_user_i;
	assign mem_q_data_o = merged_data;
	assign in_p_data_o  = mem_p_data_i;
	assign in_p_user_o  = mem_p_user_i;

	always_comb begin
		state_d   = state_q;
		rd_data_d = rd_data_q;
		// Pass-through by default
		mem_q_valid_o = in_q_valid_i;
		mem_q_write_o = in_q_write_i;
		// Reads go out with a full strobe, the memory sees no partial strobe
		mem_q_strb_o  = in_q_write_i ? in_q_strb_i : mem_cfg_pkg::FullStrb;
		in_q_ready_o  = mem_q_ready_i;
		in_p_valid_o  = mem_p_valid_i;
		mem_p_ready_o = in_p_ready_i;

		unique case (state_q)
			rmw_pkg::ST_IDLE_READ: begin
				if (in_q_valid_i && partial_write) begin
					// Hold the partial write upstream and send a read instead
					in_q_ready_o  = 1'b0;
					mem_q_valid_o = 1'b1;
					mem_q_write_o = 1'b0;
					mem_q_strb_o  = mem_cfg_pkg::FullStrb;
					if (mem_q_ready_i) begin
						state_d = rmw_pkg::ST_WRITE;
					end else begin
						state_d = rmw_pkg::ST_READ_WAIT;
					end
				end
			end
			rmw_pkg::ST_READ_WAIT: begin
				// Keep the inserted read up until the memory takes it
				in_q_ready_o  = 1'b0;
				mem_q_valid_o = 1'b1;
				mem_q_write_o = 1'b0;
				mem_q_strb_o  = mem_cfg_pkg::FullStrb;
				if (mem_q_ready_i) begin
					state_d = rmw_pkg::ST_WRITE;
				end
			end
			rmw_pkg::ST_WRITE: begin
				in_q_ready_o  = 1'b0;
				mem_q_valid_o = 1'b0;
				if (rsp_match) begin
					// Swallow the read response, it never reaches the core
					mem_p_ready_o = 1'b1;
					in_p_valid_o  = 1'b0;
					rd_data_d     = mem_p_data_i;
					// Merged word goes out in the same cycle
					mem_q_valid_o = 1'b1;
					mem_q_write_o = 1'b1;
					mem_q_strb_o  = mem_cfg_pkg::FullStrb;
					// Upstream entry retires with the merged write
					in_q_ready_o  = mem_q_ready_i;
					if (mem_q_ready_i) begin
						state_d = rmw_pkg::ST_IDLE_READ;
					end else begin
						state_d = rmw_pkg::ST_WRITE_WAIT;
					end
				end
			end
			rmw_pkg::ST_WRITE_WAIT: begin
				// Merged write held, in_q_ready follows the memory
				mem_q_valid_o = 1'b1;
				mem_q_write_o = 1'b1;
				mem_q_strb_o  = mem_cfg_pkg::FullStrb;
				if (mem_q_ready_i) begin
					state_d = rmw_pkg::ST_IDLE_READ;
				end
			end
			default: begin
				state_d = rmw_pkg::ResetState;
			end
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q   <= rmw_pkg::ResetState;
			rd_data_q <= '0;
		end else begin
			state_q   <= state_d;
			rd_data_q <= rd_data_d;
		end
	end

	// Byte mux, new byte where strobed, old byte otherwise
	for (genvar b = 0; b < mem_cfg_pkg::StrbWidth; b++) begin : g_byte_merge
		assign merged_data[b*rmw_pkg::ByteWidth +: rmw_pkg::ByteWidth] = in_q_strb_i[b] ?
			in_q_data_i[b*rmw_pkg::ByteWidth +: rmw_pkg::ByteWidth] :
			rd_data_d[b*rmw_pkg::ByteWidth +: rmw_pkg::ByteWidth];
	end

	// Every request towards the memory carries a full strobe
	a_full_strb : assert property (@(posedge clk_i) disable iff (!rst_n_i)
		mem_q_valid_o |-> (mem_q_strb_o == mem_cfg_pkg::FullStrb))
		else $error("partial strobe sent to the memory");

	// No response reaches the core between the inserted read and the merged write
	a_hide_read_rsp : assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(state_q == rmw_pkg::ST_WRITE) |-> !in_p_valid_o)
		else $error("inserted read response forwarded to the core");

endmodule

/* sources.f */
rtl/mem_cfg_pkg.sv
rtl/rmw_pkg.sv
rtl/req_spill_reg.sv
rtl/strbreq_handler.sv
rtl/nostrb_mem.sv
rtl/strb_subsys_top.sv
test/strb_subsys_tb.sv

/* test/strb_subsys_tb.sv */
// ############################
// Byte strobe subsystem bench
// Shadow memory, random core
// requests one at a time and
// concurrent response checks
// ############################

`timescale 1ns/1ps

module strb_subsys_tb;

	localparam int WaitLimit = 64;
	localparam int NumRandom = 200;

	logic                              clk_i = 1'b0;
	logic                              rst_n_i;
	logic                              core_q_valid_i;
	logic [mem_cfg_pkg::AddrWidth-1:0] core_q_addr_i;
	logic                              core_q_write_i;
	logic [mem_cfg_pkg::DataWidth-1:0] core_q_data_i;
	logic [mem_cfg_pkg::StrbWidth-1:0] core_q_strb_i;
	logic [mem_cfg_pkg::UserWidth-1:0] core_q_user_i;
	logic                              core_q_ready_o;
	logic                              core_p_ready_i = 1'b0;
	logic                              core_p_valid_o;
	logic [mem_cfg_pkg::DataWidth-1:0] core_p_data_o;
	logic [mem_cfg_pkg::UserWidth-1:0] core_p_user_o;

	// Reference copy of the memory contents
	logic [mem_cfg_pkg::DataWidth-1:0] shadow [2**mem_cfg_pkg::AddrWidth];
	logic [mem_cfg_pkg::DataWidth-1:0] exp_data;
	logic [mem_cfg_pkg::UserWidth-1:0] exp_user;
	logic [mem_cfg_pkg::UserWidth-1:0] tag;
	// Request accepted and response not yet taken
	logic pending;
	int req_count;
	int rsp_count;
	int err_data = 0;
	int err_user = 0;
	int err_rsp = 0;
	int err_stall = 0;
	int err_rst_valid = 0;
	int err_rst_ready = 0;
	int err_count = 0;
	int timeouts = 0;

	strb_subsys_top DUT (.*);

	always #50 clk_i = ~clk_i;

	// Response ready drops about one cycle in four
	always @(posedge clk_i) begin
		logic [31:0] r;
		r = $urandom;
		core_p_ready_i <= (r[1:0] != 2'b00);
	end

	// Track outstanding requests from the core handshakes
	always @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pending   <= 1'b0;
			req_count <= 0;
			rsp_count <= 0;
		end else begin
			if (core_p_valid_o && core_p_ready_i) begin
				pending   <= 1'b0;
				rsp_count <= rsp_count + 1;
			end
			if (core_q_valid_i && core_q_ready_o) begin
				pending   <= 1'b1;
				req_count <= req_count + 1;
			end
		end
	end

	// Idle outputs right after reset
	a_reset_valid : assert property (@(posedge clk_i) $rose(rst_n_i) |-> !core_p_valid_o)
		else begin
			err_rst_valid++;
			$display("ERR %0t core_p_valid_o expected 0 actual %b", $time,
				$sampled(core_p_valid_o));
		end

	a_reset_ready : assert property (@(posedge clk_i) $rose(rst_n_i) |-> core_q_ready_o)
		else begin
			err_rst_ready++;
			$display("ERR %0t core_q_ready_o expected 1 actual %b", $time,
				$sampled(core_q_ready_o));
		end

	// Response word against the shadow memory
	a_rsp_data : assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(core_p_valid_o && core_p_ready_i) |-> (core_p_data_o == exp_data))
		else begin
			err_data++;
			$display("ERR %0t core_p_data_o expected %h actual %h", $time,
				$sampled(exp_data), $sampled(core_p_data_o));
		end

	// Tag of the one outstanding request
	a_rsp_user : assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(core_p_valid_o && core_p_ready_i) |-> (core_p_user_o == exp_user))
		else begin
			err_user++;
			$display("ERR %0t core_p_user_o expected %h actual %h", $time,
				$sampled(exp_user), $sampled(core_p_user_o));
		end

	// A response with nothing outstanding is a duplicate or a stray
	a_one_rsp : assert property (@(posedge clk_i) disable iff (!rst_n_i)
		core_p_valid_o |-> pending)
		else begin
			err_rsp++;
			$display("Response seen with no request outstanding at %0t", $time);
		end

	a_rsp_stall : assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(core_p_valid_o && !core_p_ready_i) |=>
		(core_p_valid_o && $stable(core_p_data_o) && $stable(core_p_user_o)))
		else begin
			err_stall++;
			$display("Stalled response dropped or changed at %0t", $time);
		end

	// Strobed bytes come from the new word
	function automatic logic [mem_cfg_pkg::DataWidth-1:0] merge_bytes(
		input logic [mem_cfg_pkg::DataWidth-1:0] old_word,
		input logic [mem_cfg_pkg::DataWidth-1:0] new_word,
		input logic [mem_cfg_pkg::StrbWidth-1:0] strb
	);
		logic [mem_cfg_pkg::DataWidth-1:0] result;
		result = old_word;
		for (int b = 0; b < mem_cfg_pkg::StrbWidth; b++) begin
			if (strb[b]) begin
				result[b*8 +: 8] = new_word[b*8 +: 8];
			end
		end
		return result;
	endfunction

	// One request and its response with bounded waits
	task automatic send_request(
		input logic [mem_cfg_pkg::AddrWidth-1:0] addr,
		input logic                              wr,
		input logic [mem_cfg_pkg::DataWidth-1:0] data,
		input logic [mem_cfg_pkg::StrbWidth-1:0] strb
	);
		int cycles;
		logic accepted;
		logic answered;
		// Writes answer with the merged word and reads with the stored one
		if (wr) begin
			shadow[addr] = merge_bytes(shadow[addr], data, strb);
		end
		exp_data = shadow[addr];
		exp_user = tag;
		core_q_valid_i <= 1'b1;
		core_q_addr_i  <= addr;
		core_q_write_i <= wr;
		core_q_data_i  <= data;
		core_q_strb_i  <= strb;
		core_q_user_i  <= tag;
		// Ready is settled at the falling edge
		cycles   = 0;
		accepted = 1'b0;
		while (!accepted && cycles < WaitLimit) begin
			@(negedge clk_i);
			if (core_q_ready_o) accepted = 1'b1;
			else cycles++;
		end
		@(posedge clk_i);
		core_q_valid_i <= 1'b0;
		tag = tag + 1'b1;
		if (!accepted) begin
			timeouts++;
			$display("Timeout: request with tag %0d never accepted, %0t", exp_user, $time);
		end else begin
			cycles   = 0;
			answered = 1'b0;
			while (!answered && cycles < WaitLimit) begin
				@(negedge clk_i);
				if (core_p_valid_o && core_p_ready_i) answered = 1'b1;
				else cycles++;
			end
			@(posedge clk_i);
			if (!answered) begin
				timeouts++;
				$display("Timeout: no response for tag %0d, %0t", exp_user, $time);
			end
		end
	endtask

	initial begin
		logic [31:0] rnd;
		logic [mem_cfg_pkg::AddrWidth-1:0] addr;
		logic [mem_cfg_pkg::StrbWidth-1:0] strb;
		int total;
		void'($urandom(32'hfd96));
		rst_n_i        = 1'b0;
		core_q_valid_i = 1'b0;
		core_q_addr_i  = '0;
		core_q_write_i = 1'b0;
		core_q_data_i  = '0;
		core_q_strb_i  = '0;
		core_q_user_i  = '0;
		tag            = '0;
		exp_data       = '0;
		exp_user       = '0;
		for (int i = 0; i < 2**mem_cfg_pkg::AddrWidth; i++) begin
			shadow[i] = '0;
		end
		repeat (3) @(posedge clk_i);
		rst_n_i <= 1'b1;

		// Unwritten word then full and partial writes each read back
		send_request(8'h03, 1'b0, 32'h0000_0000, 4'hf);
		send_request(8'h03, 1'b1, 32'hcafe_1234, 4'hf);
		send_request(8'h03, 1'b0, 32'h0000_0000, 4'hf);
		send_request(8'h03, 1'b1, 32'h5a5a_a5a5, 4'b0101);
		send_request(8'h03, 1'b0, 32'h0000_0000, 4'hf);

		// Random mix over the low 16 words
		for (int n = 0; n < NumRandom && timeouts == 0; n++) begin
			rnd = $urandom;
			addr = '0;
			addr[3:0] = rnd[3:0];
			strb = rnd[8 +: mem_cfg_pkg::StrbWidth];
			if (rnd[5:4] == 2'b00) strb = mem_cfg_pkg::FullStrb;
			send_request(addr, rnd[6], $urandom, strb);
		end
		repeat (2) @(posedge clk_i);

		a_rsp_count : assert (rsp_count == req_count)
			else begin
				err_count++;
				$display("Got %0d responses for %0d requests", rsp_count, req_count);
			end

		total = err_data + err_user + err_rsp + err_stall + err_rst_valid + err_rst_ready
			+ err_count + timeouts;
		$display("Errors data %0d tag %0d extra %0d stall %0d reset %0d count %0d timeout %0d",
			err_data, err_user, err_rsp, err_stall, err_rst_valid + err_rst_ready,
			err_count, timeouts);
		if (total == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule
